//--- src/aluPkg.sv
// ------------------------------------------------
// opcodes 1100 to 1111 are memory ops, never executed here
// flag word is fixed at 4 bits, N Z C V from msb down
// ------------------------------------------------
`default_nettype none

package aluPkg;

    // 4-bit opcode field of the instruction
    typedef enum logic [3:0] {
        opAdd    = 4'b0000,
        opSub    = 4'b0001,
        opMul    = 4'b0010,
        opOr     = 4'b0011,
        opAnd    = 4'b0100,
        opXor    = 4'b0101,
        // 16-bit immediate, zero extended
        opMovImm = 4'b0110,
        opMov    = 4'b0111,
        opLsr    = 4'b1000,
        opLsl    = 4'b1001,
        opRor    = 4'b1010,
        // flags only, no register write
        opCmp    = 4'b1011,
        // memory group, out of scope for this stage
        opAdr    = 4'b1100,
        opLdr    = 4'b1101,
        opStr    = 4'b1110,
        opRsvd   = 4'b1111
    } aluOpE;

    // bit positions inside the flag word
    localparam int flagN = 3;
    localparam int flagZ = 2;
    localparam int flagC = 1;
    localparam int flagV = 0;

endpackage

`default_nettype wire

//--- src/condPkg.sv
// ------------------------------------------------
// codes 1001 to 1111 are undefined and never pass
// ------------------------------------------------
`default_nettype none

package condPkg;

    // condition field, checked against flags before the instruction
    typedef enum logic [3:0] {
        // unconditional
        condAl = 4'b0000,
        // equal, Z set
        condEq = 4'b0001,
        // signed greater than
        condGt = 4'b0010,
        // signed less than
        condLt = 4'b0011,
        // signed greater or equal
        condGe = 4'b0100,
        // signed less or equal
        condLe = 4'b0101,
        // unsigned higher
        condHi = 4'b0110,
        // carry clear
        condCc = 4'b0111,
        // carry set
        condCs = 4'b1000
    } condCodeE;

endpackage

`default_nettype wire

//--- src/condCheck.sv
// ------------------------------------------------
// purely combinational, flags are the stored ones
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module condCheck (
    input  condPkg::condCodeE cond,
    input  logic [3:0]        curFlags,
    output logic              pass
);
    import condPkg::*;
    import aluPkg::*;

    logic flN;
    logic flZ;
    logic flC;
    logic flV;

    // unpack the stored flag word
    assign flN = curFlags[flagN];
    assign flZ = curFlags[flagZ];
    assign flC = curFlags[flagC];
    assign flV = curFlags[flagV];

    always_comb
    begin
        case (cond)
            condAl: pass = 1'b1;
            condEq: pass = flZ;
            // not zero and sign matches overflow
            condGt: pass = !flZ && (flN == flV);
            condLt: pass = (flN != flV);
            condGe: pass = (flN == flV);
            condLe: pass = flZ || (flN != flV);
            // unsigned higher: carry and not zero
            condHi: pass = flC && !flZ;
            condCc: pass = !flC;
            condCs: pass = flC;
            // undefined codes
            default: pass = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/arithUnit.sv
// ------------------------------------------------
// one shared adder for ADD, SUB and CMP; C is no-borrow on sub
// MUL keeps only the low dataWidth bits of the product
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module arithUnit #(
    parameter int dataWidth = 32
) (
    input  aluPkg::aluOpE         opCode,
    input  logic [dataWidth-1:0]  opA,
    input  logic [dataWidth-1:0]  opB,
    input  logic [3:0]            curFlags,
    output logic [dataWidth-1:0]  arithResult,
    output logic [3:0]            arithFlags
);
    import aluPkg::*;

    logic                 isSub;
    logic [dataWidth-1:0] addB;
    logic [dataWidth:0]   sumFull;
    logic [dataWidth-1:0] sum;
    logic                 carryOut;
    logic                 overflow;
    logic [dataWidth-1:0] product;

    // sub and cmp share the adder as A + ~B + 1
    assign isSub = (opCode == opSub) || (opCode == opCmp);
    assign addB  = isSub ? ~opB : opB;

    assign sumFull  = {1'b0, opA} + {1'b0, addB} + {{dataWidth{1'b0}}, isSub};
    assign sum      = sumFull[dataWidth-1:0];
    // carry out, which for subtract means opA >= opB unsigned
    assign carryOut = sumFull[dataWidth];

    // signed overflow: same input signs, different result sign
    assign overflow = (opA[dataWidth-1] == addB[dataWidth-1]) &&
                      (sum[dataWidth-1] != opA[dataWidth-1]);

    // low half of the product only
    assign product = opA * opB;

    always_comb
    begin
        arithResult = '0;
        arithFlags  = curFlags;
        case (opCode)
            opAdd, opSub, opCmp:
            begin
                arithResult       = sum;
                arithFlags[flagN] = sum[dataWidth-1];
                arithFlags[flagZ] = (sum == '0);
                arithFlags[flagC] = carryOut;
                arithFlags[flagV] = overflow;
            end
            opMul:
            begin
                // C and V stay as they were
                arithResult       = product;
                arithFlags[flagN] = product[dataWidth-1];
                arithFlags[flagZ] = (product == '0);
            end
            default:
            begin
                // not an arithmetic op, result unused upstream
                arithResult = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/logicShiftUnit.sv
// ------------------------------------------------
// shifts act on opB by shiftAmt; zero amount keeps C
// needs dataWidth of at least 16 for the MOVn immediate
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module logicShiftUnit #(
    parameter int dataWidth = 32
) (
    input  aluPkg::aluOpE         opCode,
    input  logic [dataWidth-1:0]  opA,
    input  logic [dataWidth-1:0]  opB,
    input  logic [4:0]            shiftAmt,
    input  logic [15:0]           imm16,
    input  logic [3:0]            curFlags,
    output logic [dataWidth-1:0]  lsResult,
    output logic [3:0]            lsFlags
);
    import aluPkg::*;

    logic [dataWidth:0]     lslWide;
    logic [dataWidth:0]     lsrWide;
    logic [2*dataWidth-1:0] rorWide;
    logic [dataWidth-1:0]   movImm;
    logic                   shifting;
    logic                   setNz;

    // extra bit above catches the last bit shifted out on the left
    assign lslWide = {1'b0, opB} << shiftAmt;
    // extra bit below catches the last bit shifted out on the right
    assign lsrWide = {opB, 1'b0} >> shiftAmt;
    // doubled word, low half is the rotated value
    assign rorWide = {opB, opB} >> shiftAmt;

    assign movImm   = {{(dataWidth-16){1'b0}}, imm16};
    assign shifting = (shiftAmt != 5'd0);

    always_comb
    begin
        lsResult = '0;
        lsFlags  = curFlags;
        setNz    = 1'b0;
        case (opCode)
            opOr:
            begin
                lsResult = opA | opB;
                setNz    = 1'b1;
            end
            opAnd:
            begin
                lsResult = opA & opB;
                setNz    = 1'b1;
            end
            opXor:
            begin
                lsResult = opA ^ opB;
                setNz    = 1'b1;
            end
            // moves leave every flag alone
            opMov:    lsResult = opB;
            opMovImm: lsResult = movImm;
            opLsl:
            begin
                lsResult = lslWide[dataWidth-1:0];
                setNz    = 1'b1;
                if (shifting)
                    lsFlags[flagC] = lslWide[dataWidth];
            end
            opLsr:
            begin
                lsResult = lsrWide[dataWidth:1];
                setNz    = 1'b1;
                if (shifting)
                    lsFlags[flagC] = lsrWide[0];
            end
            opRor:
            begin
                lsResult = rorWide[dataWidth-1:0];
                setNz    = 1'b1;
                // carry is the new msb after rotation
                if (shifting)
                    lsFlags[flagC] = rorWide[dataWidth-1];
            end
            default: lsResult = '0;
        endcase
        // V is never touched by this unit
        if (setNz)
        begin
            lsFlags[flagN] = lsResult[dataWidth-1];
            lsFlags[flagZ] = (lsResult == '0);
        end
    end

endmodule

`default_nettype wire

//--- src/masterAlu.sv
// ------------------------------------------------
// combinational; result is zero when the instruction is skipped
// memory opcodes never execute and leave flags as stored
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module masterAlu #(
    parameter int dataWidth = 32
) (
    input  aluPkg::aluOpE         opCode,
    input  condPkg::condCodeE     cond,
    input  logic                  setFlags,
    input  logic [dataWidth-1:0]  opA,
    input  logic [dataWidth-1:0]  opB,
    input  logic [4:0]            shiftAmt,
    input  logic [15:0]           imm16,
    input  logic [3:0]            curFlags,
    output logic [dataWidth-1:0]  aluResult,
    output logic [3:0]            newFlags,
    output logic                  execute,
    output logic                  writesReg
);
    import aluPkg::*;

    logic                 pass;
    logic                 isMem;
    logic                 isArith;
    logic                 takeFlags;
    logic [dataWidth-1:0] arithResult;
    logic [3:0]           arithFlags;
    logic [dataWidth-1:0] lsResult;
    logic [3:0]           lsFlags;
    logic [dataWidth-1:0] unitResult;
    logic [3:0]           unitFlags;

    condCheck u_condCheck (
        .cond     (cond),
        .curFlags (curFlags),
        .pass     (pass)
    );

    arithUnit #(
        .dataWidth (dataWidth)
    ) u_arithUnit (
        .opCode      (opCode),
        .opA         (opA),
        .opB         (opB),
        .curFlags    (curFlags),
        .arithResult (arithResult),
        .arithFlags  (arithFlags)
    );

    logicShiftUnit #(
        .dataWidth (dataWidth)
    ) u_logicShiftUnit (
        .opCode   (opCode),
        .opA      (opA),
        .opB      (opB),
        .shiftAmt (shiftAmt),
        .imm16    (imm16),
        .curFlags (curFlags),
        .lsResult (lsResult),
        .lsFlags  (lsFlags)
    );

    // ADR, LDR, STR and the reserved code
    assign isMem   = opCode inside {opAdr, opLdr, opStr, opRsvd};
    assign isArith = opCode inside {opAdd, opSub, opMul, opCmp};
    assign execute = pass && !isMem;

    // unit select by opcode group
    assign unitResult = isArith ? arithResult : lsResult;
    assign unitFlags  = isArith ? arithFlags : lsFlags;

    // skipped instructions show zero
    assign aluResult = execute ? unitResult : '0;

    // cmp always takes flags, others only with S set
    assign takeFlags = execute && (setFlags || (opCode == opCmp));
    assign newFlags  = takeFlags ? unitFlags : curFlags;

    assign writesReg = execute && (opCode != opCmp);

endmodule

`default_nettype wire

//--- src/regFile.sv
// ------------------------------------------------
// async reads, write at rising clk; all words cleared on reset
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module regFile #(
    parameter int dataWidth = 32,
    parameter int regCount  = 16
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [$clog2(regCount)-1:0] rdAddrA,
    input  logic [$clog2(regCount)-1:0] rdAddrB,
    output logic [dataWidth-1:0]        rdDataA,
    output logic [dataWidth-1:0]        rdDataB,
    input  logic                        wrEn,
    input  logic [$clog2(regCount)-1:0] wrAddr,
    input  logic [dataWidth-1:0]        wrData
);
    logic [dataWidth-1:0] regs [regCount];

    // single write port
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < regCount; i++)
                regs[i] <= '0;
        end
        else if (wrEn)
        begin
            regs[wrAddr] <= wrData;
        end
    end

    // read ports see the value already written at the last edge
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

//--- src/execStage.sv
// ------------------------------------------------
// one instruction per clk on instValid, no back-pressure
// outputs valid the cycle after issue; no memory ops
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module execStage #(
    parameter int dataWidth = 32,
    parameter int regCount  = 16
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        instValid,
    input  aluPkg::aluOpE               opCode,
    input  condPkg::condCodeE           cond,
    input  logic                        setFlags,
    input  logic [$clog2(regCount)-1:0] rd,
    input  logic [$clog2(regCount)-1:0] rn,
    input  logic [$clog2(regCount)-1:0] rm,
    input  logic [4:0]                  shiftAmt,
    input  logic [15:0]                 imm16,
    output logic                        resultValid,
    output logic                        executed,
    output logic [dataWidth-1:0]        result,
    output logic [3:0]                  flags
);
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluResult;
    logic [3:0]           curFlags;
    logic [3:0]           newFlags;
    logic                 execute;
    logic                 writesReg;
    logic                 wrEn;

    // write only for a valid, executed, register-writing op
    assign wrEn = instValid && writesReg;

    regFile #(
        .dataWidth (dataWidth),
        .regCount  (regCount)
    ) u_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (rn),
        .rdAddrB (rm),
        .rdDataA (opA),
        .rdDataB (opB),
        .wrEn    (wrEn),
        .wrAddr  (rd),
        .wrData  (aluResult)
    );

    masterAlu #(
        .dataWidth (dataWidth)
    ) u_masterAlu (
        .opCode    (opCode),
        .cond      (cond),
        .setFlags  (setFlags),
        .opA       (opA),
        .opB       (opB),
        .shiftAmt  (shiftAmt),
        .imm16     (imm16),
        .curFlags  (curFlags),
        .aluResult (aluResult),
        .newFlags  (newFlags),
        .execute   (execute),
        .writesReg (writesReg)
    );

    // NZCV register, moves only on a valid instruction
    always_ff @(posedge clk)
    begin
        if (!rstN)
            curFlags <= 4'b0000;
        else if (instValid)
            curFlags <= newFlags;
    end

    // outcome of the instruction issued at the previous edge
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            resultValid <= 1'b0;
            executed    <= 1'b0;
            result      <= '0;
        end
        else
        begin
            resultValid <= instValid;
            executed    <= instValid && execute;
            // aluResult is already zero for a skipped op
            result      <= instValid ? aluResult : '0;
        end
    end

    // stored flags, which after the edge hold the latest outcome
    assign flags = curFlags;

endmodule

`default_nettype wire

//--- verification/execStageTb.sv
// ------------------------------------------------
// reads verification/execStageTests.txt relative to the project root
// one instruction per clk back to back and each checked a cycle later
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module execStageTb;
    import aluPkg::*;
    import condPkg::*;

    localparam int dataWidth   = 32;
    localparam int clkPeriod   = 40;
    localparam int driveDelay  = 2;

    logic                 clk;
    logic                 rstN;
    logic                 instValid;
    aluOpE                opCode;
    condCodeE             cond;
    logic                 setFlags;
    logic [3:0]           rd;
    logic [3:0]           rn;
    logic [3:0]           rm;
    logic [4:0]           shiftAmt;
    logic [15:0]          imm16;
    logic                 resultValid;
    logic                 executed;
    logic [dataWidth-1:0] result;
    logic [3:0]           flags;

    // one queue per column of the data file
    string                nameQ[$];
    logic [3:0]           opQ[$];
    logic [3:0]           condQ[$];
    logic                 setQ[$];
    logic [3:0]           rdQ[$];
    logic [3:0]           rnQ[$];
    logic [3:0]           rmQ[$];
    logic [4:0]           shQ[$];
    logic [15:0]          immQ[$];
    logic                 expExeQ[$];
    logic [dataWidth-1:0] expResQ[$];
    logic [3:0]           expFlgQ[$];

    logic                 loaded;
    int                   resultErrs;
    int                   flagErrs;
    int                   execErrs;
    int                   miscErrs;

    execStage u_dut (
        .clk         (clk),
        .rstN        (rstN),
        .instValid   (instValid),
        .opCode      (opCode),
        .cond        (cond),
        .setFlags    (setFlags),
        .rd          (rd),
        .rn          (rn),
        .rm          (rm),
        .shiftAmt    (shiftAmt),
        .imm16       (imm16),
        .resultValid (resultValid),
        .executed    (executed),
        .result      (result),
        .flags       (flags)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic loadTests();
        int                   fd;
        int                   n;
        string                line;
        string                tName;
        logic [3:0]           tOp;
        logic [3:0]           tCond;
        logic                 tSet;
        logic [3:0]           tRd;
        logic [3:0]           tRn;
        logic [3:0]           tRm;
        logic [4:0]           tSh;
        logic [15:0]          tImm;
        logic                 tExe;
        logic [dataWidth-1:0] tRes;
        logic [3:0]           tFlg;
        fd = $fopen("verification/execStageTests.txt", "r");
        if (fd == 0)
        begin
            $display("could not open verification/execStageTests.txt");
            miscErrs++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                // comment and blank lines carry no test
                if (n != 0 && line.len() > 0 && line[0] != "#")
                begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h",
                                tName, tOp, tCond, tSet, tRd, tRn, tRm,
                                tSh, tImm, tExe, tRes, tFlg);
                    if (n == 12)
                    begin
                        nameQ.push_back(tName);
                        opQ.push_back(tOp);
                        condQ.push_back(tCond);
                        setQ.push_back(tSet);
                        rdQ.push_back(tRd);
                        rnQ.push_back(tRn);
                        rmQ.push_back(tRm);
                        shQ.push_back(tSh);
                        immQ.push_back(tImm);
                        expExeQ.push_back(tExe);
                        expResQ.push_back(tRes);
                        expFlgQ.push_back(tFlg);
                    end
                    else if (n > 0)
                    begin
                        $display("malformed line in test file: %0s", line);
                        miscErrs++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic checkResult(string name, logic [dataWidth-1:0] exp,
                               logic [dataWidth-1:0] act);
        if (act !== exp)
        begin
            $display("[ERROR] %0s result expected %h actual %h", name, exp, act);
            resultErrs++;
        end
    endtask

    task automatic checkFlags(string name, logic [3:0] exp, logic [3:0] act);
        if (act !== exp)
        begin
            $display("[ERROR] %0s flags expected %b actual %b", name, exp, act);
            flagErrs++;
        end
    endtask

    task automatic checkExecuted(string name, logic exp, logic act);
        if (act !== exp)
        begin
            $display("[ERROR] %0s executed expected %b actual %b", name, exp, act);
            execErrs++;
        end
    endtask

    // apply one instruction for a single cycle
    task automatic driveInst(int i);
        instValid = 1'b1;
        opCode    = aluOpE'(opQ[i]);
        cond      = condCodeE'(condQ[i]);
        setFlags  = setQ[i];
        rd        = rdQ[i];
        rn        = rnQ[i];
        rm        = rmQ[i];
        shiftAmt  = shQ[i];
        imm16     = immQ[i];
    endtask

    // outputs of the instruction issued one edge earlier
    task automatic checkOutcome(int i);
        if (resultValid !== 1'b1)
        begin
            $display("test %0s: resultValid did not pulse in the cycle after issue",
                     nameQ[i]);
            miscErrs++;
        end
        checkExecuted(nameQ[i], expExeQ[i], executed);
        checkResult(nameQ[i], expResQ[i], result);
        checkFlags(nameQ[i], expFlgQ[i], flags);
    endtask

    // watchdog sized from the number of tests read
    initial
    begin
        wait (loaded === 1'b1);
        #((nameQ.size() + 10) * 4 * clkPeriod);
        $display("watchdog timeout, the run did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        rstN       = 1'b0;
        instValid  = 1'b0;
        opCode     = opAdd;
        cond       = condAl;
        setFlags   = 1'b0;
        rd         = '0;
        rn         = '0;
        rm         = '0;
        shiftAmt   = '0;
        imm16      = '0;
        loaded     = 1'b0;
        resultErrs = 0;
        flagErrs   = 0;
        execErrs   = 0;
        miscErrs   = 0;

        loadTests();
        if (nameQ.size() == 0)
        begin
            $display("no tests were read from the test file");
            miscErrs++;
        end
        loaded = 1'b1;

        repeat (5) @(posedge clk);
        #driveDelay;
        rstN = 1'b1;

        // state straight out of reset
        checkFlags("after_reset", 4'b0000, flags);
        if (resultValid !== 1'b0)
        begin
            $display("resultValid is high right after reset");
            miscErrs++;
        end

        for (int i = 0; i < nameQ.size(); i++)
        begin
            @(posedge clk);
            #driveDelay;
            if (i > 0)
                checkOutcome(i - 1);
            driveInst(i);
        end

        @(posedge clk);
        #driveDelay;
        if (nameQ.size() > 0)
            checkOutcome(nameQ.size() - 1);
        instValid = 1'b0;

        // pulse must drop once the stream stops
        @(posedge clk);
        #driveDelay;
        if (resultValid !== 1'b0)
        begin
            $display("resultValid stayed high with no instruction issued");
            miscErrs++;
        end

        $display("errors: result %0d, flags %0d, executed %0d, other %0d",
                 resultErrs, flagErrs, execErrs, miscErrs);
        if (resultErrs + flagErrs + execErrs + miscErrs == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- execStage.f
src/aluPkg.sv
src/condPkg.sv
src/condCheck.sv
src/arithUnit.sv
src/logicShiftUnit.sv
src/masterAlu.sv
src/regFile.sv
src/execStage.sv
verification/execStageTb.sv

//--- verification/execStageTests.txt
# columns: name opcode cond setFlags rd rn rm shiftAmt imm16 expExecuted expResult expFlags
# every field after the name is hex; flags are NZCV, as stored after the instruction
movn_r1   6 0 0 1 0 0 00 7fff 1 00007fff 0
movn_r2   6 0 0 2 0 0 00 ffff 1 0000ffff 0
movn_r3   6 0 0 3 0 0 00 0001 1 00000001 0
movn_r4   6 0 0 4 0 0 00 8000 1 00008000 0
mov_r5    7 0 1 5 0 1 00 0000 1 00007fff 0
lsl_r6    9 0 1 6 0 4 10 0000 1 80000000 8
add_s     0 0 1 7 6 6 00 0000 1 00000000 7
sub_neg   1 0 1 8 0 3 00 0000 1 ffffffff 8
xor_r9    5 0 1 9 8 6 00 0000 1 7fffffff 0
add_vpos  0 0 1 a 9 3 00 0000 1 80000000 9
sub_s     1 0 1 b 1 3 00 0000 1 00007ffe 2
sub_nf    1 0 0 b 3 1 00 0000 1 ffff8002 2
sub_vneg  1 0 1 c 6 3 00 0000 1 7fffffff 3
mul_s     2 0 1 d 2 2 00 0000 1 fffe0001 b
mul_nf    2 0 0 e 1 3 00 0000 1 00007fff b
or_s      3 0 1 e 6 1 00 0000 1 80007fff b
and_zero  4 0 1 f 6 1 00 0000 1 00000000 7
xor_nf    5 0 0 f 2 1 00 0000 1 00008000 7
lsr_s     8 0 1 f 0 2 04 0000 1 00000fff 3
lsl_c     9 0 1 f 0 8 01 0000 1 fffffffe b
lsr_amt0  8 0 1 f 0 8 00 0000 1 ffffffff b
ror_c0    a 0 1 f 0 4 04 0000 1 00000800 1
ror_amt0  a 0 1 f 0 6 00 0000 1 80000000 9
cmp_lt    b 0 0 1 3 1 00 0000 1 ffff8002 8
mov_r1    7 0 0 2 0 1 00 0000 1 00007fff 8
c_lt      6 3 0 e 0 0 00 0033 1 00000033 8
c_ge_f    6 4 0 e 0 0 00 0044 0 00000000 8
mov_r14a  7 0 0 d 0 e 00 0000 1 00000033 8
c_cc      6 7 0 e 0 0 00 0077 1 00000077 8
c_gt_f    0 2 1 e 1 1 00 0000 0 00000000 8
cmp_eq    b 0 0 1 1 5 00 0000 1 00000000 6
c_eq      6 1 0 e 0 0 00 0011 1 00000011 6
c_le      6 5 0 e 0 0 00 0055 1 00000055 6
c_hi_f    6 6 0 e 0 0 00 0066 0 00000000 6
c_cs      6 8 0 e 0 0 00 0088 1 00000088 6
cmp_gt    b 0 0 1 1 3 00 0000 1 00007ffe 2
c_gt      6 2 0 e 0 0 00 0022 1 00000022 2
c_hi      6 6 0 e 0 0 00 0066 1 00000066 2
c_undef9  0 9 1 e 1 1 00 0000 0 00000000 2
mem_adr   c 0 1 e 1 1 00 0000 0 00000000 2
mem_rsvd  f 0 1 e 1 1 00 0000 0 00000000 2
mov_r14b  7 0 0 d 0 e 00 0000 1 00000066 2
b2b_add1  0 0 0 3 3 3 00 0000 1 00000002 2
b2b_add2  0 0 0 3 3 3 00 0000 1 00000004 2
b2b_lsl   9 0 0 3 0 3 04 0000 1 00000040 2
b2b_add3  0 0 1 3 3 1 00 0000 1 0000803f 0
